//--- bpred_pkg.sv
// Shared branch predictor definitions: PC width, RV32 opcodes, saturating counter type and values
package bpred_pkg;

    // Width of a PC and of a branch target
    localparam int xlen = 32;

    // RV32 major opcode field
    typedef logic [6:0] opcode_t;

    // Opcodes that steer a predictor update
    // jal and jalr are handled the same way
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;

    // 2-bit saturating direction counter
    // Upper bit is the taken prediction
    typedef logic [1:0] ctr_t;

    // Saturation limits
    localparam ctr_t ctr_strong_nt = 2'd0;
    localparam ctr_t ctr_strong_t  = 2'd3;

    // Counter value held by every PHT entry after reset
    localparam ctr_t ctr_reset = ctr_strong_nt;

endpackage

//--- bpred_btb.sv
// Direct-mapped branch target buffer with tag, target, jump/branch flags and lookup hit logic
`timescale 1ns/100ps

module bpred_btb import bpred_pkg::*; #(
    parameter int num_btb_entries = 4
) (
    input  logic            clk,
    input  logic            reset_i,

    // Lookup port
    input  logic [xlen-1:0] lookup_pc_i,
    output logic            hit_o,
    output logic            hit_jump_o,
    output logic            hit_branch_o,
    output logic [xlen-1:0] target_o,

    // Write port
    input  logic            wr_en_i,
    input  logic [xlen-1:0] wr_pc_i,
    input  logic [xlen-1:0] wr_target_i,
    input  logic            wr_is_jump_i,
    input  logic            wr_is_branch_i
);

    localparam int idx_bits = $clog2(num_btb_entries);

    // Entry storage
    logic [xlen-1:0] tag_q    [num_btb_entries];
    logic [xlen-1:0] target_q [num_btb_entries];
    logic            jump_q   [num_btb_entries];
    logic            branch_q [num_btb_entries];
    logic [num_btb_entries-1:0] valid_q;

    logic [idx_bits-1:0] lookup_idx;
    logic [idx_bits-1:0] wr_idx;
    logic                tag_match;

    // Word-aligned PCs, so the index skips the two low bits
    assign lookup_idx = lookup_pc_i[idx_bits+1:2];
    assign wr_idx     = wr_pc_i[idx_bits+1:2];

    // Full PC is kept as the tag
    assign tag_match = (tag_q[lookup_idx] == lookup_pc_i);

    assign hit_o        = valid_q[lookup_idx] && tag_match;
    assign hit_jump_o   = hit_o && jump_q[lookup_idx];
    assign hit_branch_o = hit_o && branch_q[lookup_idx];
    assign target_o     = target_q[lookup_idx];

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry payload, always overwritten on a write so a new target replaces the old one
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[wr_idx]    <= wr_pc_i;
            target_q[wr_idx] <= wr_target_i;
            jump_q[wr_idx]   <= wr_is_jump_i;
            branch_q[wr_idx] <= wr_is_branch_i;
        end
    end

endmodule

//--- bpred_gshare.sv
// Gshare direction predictor: PHT of saturating counters, global history, index hash and training
`timescale 1ns/100ps

module bpred_gshare import bpred_pkg::*; #(
    parameter int num_ghr_bits = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,

    // Read path
    input  logic [xlen-1:0]         lookup_pc_i,
    output logic [num_ghr_bits-1:0] index_o,
    output logic                    predict_taken_o,

    // History control and training
    input  logic                    ghr_clear_i,
    input  logic                    train_en_i,
    input  logic [num_ghr_bits-1:0] train_index_i,
    input  logic                    train_taken_i
);

    localparam int num_pht_entries = 1 << num_ghr_bits;

    ctr_t                    pht_q [num_pht_entries];
    logic [num_ghr_bits-1:0] ghr_q;
    ctr_t                    train_ctr;
    ctr_t                    train_ctr_next;

    // One saturating step toward the actual outcome
    function automatic ctr_t ctr_step(ctr_t cur, logic taken);
        ctr_t nxt;
        nxt = cur;
        if (taken && cur != ctr_strong_t) begin
            nxt = cur + 2'd1;
        end else if (!taken && cur != ctr_strong_nt) begin
            nxt = cur - 2'd1;
        end
        return nxt;
    endfunction

    // Hash of word-aligned PC with history
    assign index_o         = lookup_pc_i[num_ghr_bits+1:2] ^ ghr_q;
    assign predict_taken_o = pht_q[index_o][1];

    assign train_ctr      = pht_q[train_index_i];
    assign train_ctr_next = ctr_step(train_ctr, train_taken_i);

    // Counter table
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < num_pht_entries; i++) begin
                pht_q[i] <= ctr_reset;
            end
        end else if (train_en_i) begin
            pht_q[train_index_i] <= train_ctr_next;
        end
    end

    // Global history, newest outcome enters at the MSB
    // Clear wins over a shift in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (train_en_i) begin
            ghr_q <= {train_taken_i, ghr_q[num_ghr_bits-1:1]};
        end
    end

endmodule

//--- bpred_next_pc.sv
// Next fetch address and taken flag selection from BTB and direction predictor results
`timescale 1ns/100ps

module bpred_next_pc import bpred_pkg::*; (
    input  logic [xlen-1:0] pc_i,
    input  logic            hit_i,
    input  logic            hit_jump_i,
    input  logic            hit_branch_i,
    input  logic [xlen-1:0] btb_target_i,
    input  logic            dir_taken_i,
    output logic [xlen-1:0] next_pc_o,
    output logic            taken_o
);

    logic [xlen-1:0] pc_plus4;

    // Sequential fall-through
    assign pc_plus4 = pc_i + xlen'(4);

    always_comb begin
        taken_o   = 1'b0;
        next_pc_o = pc_plus4;
        if (hit_i) begin
            if (hit_jump_i) begin
                // Unconditional, always redirect
                taken_o   = 1'b1;
                next_pc_o = btb_target_i;
            end else if (hit_branch_i) begin
                taken_o = dir_taken_i;
                if (dir_taken_i) begin
                    next_pc_o = btb_target_i;
                end
            end
        end
    end

endmodule

//--- bpred_update_ctrl.sv
// Four-phase req/ack update receiver with opcode decode and one-cycle table write strobes
`timescale 1ns/100ps

module bpred_update_ctrl import bpred_pkg::*; #(
    parameter int num_ghr_bits = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,

    // Execute-stage update request
    input  logic                    upd_req_i,
    input  logic [xlen-1:0]         upd_pc_i,
    input  opcode_t                 upd_op_i,
    input  logic                    upd_taken_i,
    input  logic [xlen-1:0]         upd_target_i,
    input  logic [num_ghr_bits-1:0] upd_pht_index_i,
    output logic                    upd_ack_o,

    // BTB write port
    output logic                    btb_we_o,
    output logic [xlen-1:0]         btb_pc_o,
    output logic [xlen-1:0]         btb_target_o,
    output logic                    btb_is_jump_o,
    output logic                    btb_is_branch_o,

    // PHT training port
    output logic                    pht_we_o,
    output logic [num_ghr_bits-1:0] pht_index_o,
    output logic                    pht_taken_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_ack
    } state_t;

    state_t state_q;

    // Latched request
    logic [xlen-1:0]         pc_q;
    logic [xlen-1:0]         target_q;
    logic                    taken_q;
    logic [num_ghr_bits-1:0] index_q;
    logic                    is_jump_q;
    logic                    is_branch_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle:  if (upd_req_i) state_q <= st_write;
                st_write: state_q <= st_ack;
                // Hold ack until the requester drops req
                st_ack:   if (!upd_req_i) state_q <= st_idle;
                default:  state_q <= st_idle;
            endcase
        end
    end

    // Capture payload and decode the opcode once on acceptance
    always_ff @(posedge clk) begin
        if (state_q == st_idle && upd_req_i) begin
            pc_q        <= upd_pc_i;
            target_q    <= upd_target_i;
            taken_q     <= upd_taken_i;
            index_q     <= upd_pht_index_i;
            is_jump_q   <= (upd_op_i == op_jal) || (upd_op_i == op_jalr);
            is_branch_q <= (upd_op_i == op_branch);
        end
    end

    // Non-control opcodes raise no strobe but still complete the handshake
    assign btb_we_o  = (state_q == st_write) && (is_jump_q || is_branch_q);
    assign pht_we_o  = (state_q == st_write) && is_branch_q;
    assign upd_ack_o = (state_q == st_ack);

    assign btb_pc_o        = pc_q;
    assign btb_target_o    = target_q;
    assign btb_is_jump_o   = is_jump_q;
    assign btb_is_branch_o = is_branch_q;
    assign pht_index_o     = index_q;
    assign pht_taken_o     = taken_q;

endmodule

//--- bpred_top.sv
// Branch predictor top level: BTB, gshare, next-PC select and update controller
`timescale 1ns/100ps

module bpred_top import bpred_pkg::*; #(
    parameter int num_btb_entries = 4,
    parameter int num_ghr_bits    = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,

    // Fetch lookup
    input  logic [xlen-1:0]         pc_i,
    output logic [xlen-1:0]         pred_next_pc_o,
    output logic                    pred_taken_o,
    output logic [num_ghr_bits-1:0] pht_index_o,

    // Execute-stage feedback
    input  logic                    ghr_clear_i,
    input  logic                    upd_req_i,
    input  logic [xlen-1:0]         upd_pc_i,
    input  opcode_t                 upd_op_i,
    input  logic                    upd_taken_i,
    input  logic [xlen-1:0]         upd_target_i,
    input  logic [num_ghr_bits-1:0] upd_pht_index_i,
    output logic                    upd_ack_o
);

    // Lookup results
    logic            btb_hit;
    logic            btb_hit_jump;
    logic            btb_hit_branch;
    logic [xlen-1:0] btb_target;
    logic            dir_taken;

    // Update strobes and payload
    logic                    btb_we;
    logic [xlen-1:0]         btb_wr_pc;
    logic [xlen-1:0]         btb_wr_target;
    logic                    btb_wr_is_jump;
    logic                    btb_wr_is_branch;
    logic                    pht_we;
    logic [num_ghr_bits-1:0] pht_wr_index;
    logic                    pht_wr_taken;

    bpred_btb #(
        .num_btb_entries (num_btb_entries)
    ) u_btb (
        .clk            (clk),
        .reset_i        (reset_i),
        .lookup_pc_i    (pc_i),
        .hit_o          (btb_hit),
        .hit_jump_o     (btb_hit_jump),
        .hit_branch_o   (btb_hit_branch),
        .target_o       (btb_target),
        .wr_en_i        (btb_we),
        .wr_pc_i        (btb_wr_pc),
        .wr_target_i    (btb_wr_target),
        .wr_is_jump_i   (btb_wr_is_jump),
        .wr_is_branch_i (btb_wr_is_branch)
    );

    bpred_gshare #(
        .num_ghr_bits (num_ghr_bits)
    ) u_gshare (
        .clk             (clk),
        .reset_i         (reset_i),
        .lookup_pc_i     (pc_i),
        .index_o         (pht_index_o),
        .predict_taken_o (dir_taken),
        .ghr_clear_i     (ghr_clear_i),
        .train_en_i      (pht_we),
        .train_index_i   (pht_wr_index),
        .train_taken_i   (pht_wr_taken)
    );

    bpred_next_pc u_next_pc (
        .pc_i         (pc_i),
        .hit_i        (btb_hit),
        .hit_jump_i   (btb_hit_jump),
        .hit_branch_i (btb_hit_branch),
        .btb_target_i (btb_target),
        .dir_taken_i  (dir_taken),
        .next_pc_o    (pred_next_pc_o),
        .taken_o      (pred_taken_o)
    );

    bpred_update_ctrl #(
        .num_ghr_bits (num_ghr_bits)
    ) u_update_ctrl (
        .clk             (clk),
        .reset_i         (reset_i),
        .upd_req_i       (upd_req_i),
        .upd_pc_i        (upd_pc_i),
        .upd_op_i        (upd_op_i),
        .upd_taken_i     (upd_taken_i),
        .upd_target_i    (upd_target_i),
        .upd_pht_index_i (upd_pht_index_i),
        .upd_ack_o       (upd_ack_o),
        .btb_we_o        (btb_we),
        .btb_pc_o        (btb_wr_pc),
        .btb_target_o    (btb_wr_target),
        .btb_is_jump_o   (btb_wr_is_jump),
        .btb_is_branch_o (btb_wr_is_branch),
        .pht_we_o        (pht_we),
        .pht_index_o     (pht_wr_index),
        .pht_taken_o     (pht_wr_taken)
    );

endmodule

//--- bpred_checker.sv
// Testbench monitor: reference model of BTB, PHT and GHR with lookup and handshake checks
`timescale 1ns/100ps

module bpred_checker import bpred_pkg::*; #(
    parameter int num_btb_entries = 4,
    parameter int num_ghr_bits    = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [xlen-1:0]         pc_i,
    input  logic                    ghr_clear_i,
    input  logic                    upd_req_i,
    input  logic [xlen-1:0]         upd_pc_i,
    input  opcode_t                 upd_op_i,
    input  logic                    upd_taken_i,
    input  logic [xlen-1:0]         upd_target_i,
    input  logic [num_ghr_bits-1:0] upd_pht_index_i,
    input  logic                    upd_ack_i,
    input  logic [xlen-1:0]         pred_next_pc_i,
    input  logic                    pred_taken_i,
    input  logic [num_ghr_bits-1:0] pht_index_i,
    // Lookup strobe, plus expected values when a table row drives it
    input  logic                    lookup_en_i,
    input  logic                    exp_en_i,
    input  logic [xlen-1:0]         exp_next_pc_i,
    input  logic                    exp_taken_i,
    input  logic [num_ghr_bits-1:0] exp_index_i,
    output int                      checks_o,
    output int                      mismatches_o,
    output int                      failures_o
);

    localparam int idx_bits = $clog2(num_btb_entries);

    logic [xlen-1:0]         m_tag    [num_btb_entries];
    logic [xlen-1:0]         m_target [num_btb_entries];
    logic                    m_jump   [num_btb_entries];
    logic                    m_valid  [num_btb_entries];
    ctr_t                    m_pht    [1 << num_ghr_bits];
    logic [num_ghr_bits-1:0] m_ghr;
    logic                    ack_prev;
    logic                    req_prev;
    logic                    clear_pending;
    int                      req_cycles;

    initial begin
        checks_o     = 0;
        mismatches_o = 0;
        failures_o   = 0;
    end

    task automatic compare_value(input string name, input logic [xlen-1:0] exp_v,
                                 input logic [xlen-1:0] act_v);
        checks_o++;
        if (act_v !== exp_v) begin
            mismatches_o++;
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp_v, act_v);
        end
    endtask

    task automatic report_failure(input string what);
        failures_o++;
        $display("ERROR time=%0t: %s", $time, what);
    endtask

    // Apply one resolved instruction to the model, as seen when ack rises
    task automatic apply_update();
        int e;
        int p;
        e = upd_pc_i[idx_bits+1:2];
        p = upd_pht_index_i;
        if (upd_op_i == op_jal || upd_op_i == op_jalr || upd_op_i == op_branch) begin
            m_valid[e]  = 1'b1;
            m_tag[e]    = upd_pc_i;
            m_target[e] = upd_target_i;
            m_jump[e]   = (upd_op_i != op_branch);
        end
        if (upd_op_i == op_branch) begin
            if (upd_taken_i && m_pht[p] < 3) begin
                m_pht[p] = m_pht[p] + 1;
            end else if (!upd_taken_i && m_pht[p] > 0) begin
                m_pht[p] = m_pht[p] - 1;
            end
            m_ghr = {upd_taken_i, m_ghr[num_ghr_bits-1:1]};
        end
    endtask

    task automatic check_lookup();
        int                      e;
        logic                    hit;
        logic                    taken;
        logic [xlen-1:0]         nxt;
        logic [num_ghr_bits-1:0] idx;
        e     = pc_i[idx_bits+1:2];
        idx   = pc_i[num_ghr_bits+1:2] ^ m_ghr;
        hit   = m_valid[e] && (m_tag[e] == pc_i);
        taken = hit && (m_jump[e] || m_pht[idx][1]);
        nxt   = taken ? m_target[e] : pc_i + 32'd4;
        compare_value("pred_next_pc_o", nxt, pred_next_pc_i);
        compare_value("pred_taken_o", taken, pred_taken_i);
        compare_value("pht_index_o", idx, pht_index_i);
        if (exp_en_i) begin
            compare_value("pred_next_pc_o (table)", exp_next_pc_i, pred_next_pc_i);
            compare_value("pred_taken_o (table)", exp_taken_i, pred_taken_i);
            compare_value("pht_index_o (table)", exp_index_i, pht_index_i);
        end
    endtask

    // Everything is sampled mid-cycle, where the DUT outputs are settled
    always @(negedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < num_btb_entries; i++) begin
                m_valid[i] = 1'b0;
            end
            for (int i = 0; i < (1 << num_ghr_bits); i++) begin
                m_pht[i] = ctr_reset;
            end
            m_ghr         = '0;
            ack_prev      = 1'b0;
            req_prev      = 1'b0;
            clear_pending = 1'b0;
            req_cycles    = 0;
        end else begin
            if (upd_ack_i && !ack_prev) begin
                if (req_cycles != 2) begin
                    report_failure($sformatf("ack rose %0d cycles after the request, not 2",
                                             req_cycles));
                end
                apply_update();
            end
            if (ack_prev && !upd_ack_i && req_prev) begin
                report_failure("ack dropped while the request was still high");
            end
            if (ack_prev && upd_ack_i && !req_prev) begin
                report_failure("ack still high one cycle after the request dropped");
            end
            // A clear seen last cycle took effect at the edge just passed, after any shift
            if (clear_pending) begin
                m_ghr = '0;
            end
            clear_pending = ghr_clear_i;
            if (lookup_en_i) begin
                check_lookup();
            end
            if (!upd_req_i) begin
                req_cycles = 0;
            end else if (!upd_ack_i) begin
                req_cycles++;
            end
            ack_prev = upd_ack_i;
            req_prev = upd_req_i;
        end
    end

endmodule

//--- bpred_tb.sv
// Testbench top with clock, reset, LFSR, stimulus table, handshake driver and closing report
`timescale 1ns/100ps

module bpred_tb import bpred_pkg::*;;

    localparam int      btb_entries = 4;
    localparam int      ghr_bits    = 5;
    localparam int      ack_timeout = 20;
    localparam int      num_random  = 200;
    localparam opcode_t op_none     = 7'b0110011;

    typedef enum logic [1:0] {k_update, k_lookup, k_clear} kind_t;

    // Lookup rows reuse taken, addr and idx for the expected taken, next PC and PHT index
    typedef struct packed {
        kind_t         kind;
        logic [31:0]   pc;
        opcode_t       op;
        logic          taken;
        logic [31:0]   addr;
        logic [4:0]    idx;
    } row_t;

    logic        clk;
    logic        reset;
    logic        ghr_clear;
    logic        upd_req;
    logic        upd_taken;
    logic        upd_ack;
    logic        pred_taken;
    logic        lookup_en;
    logic        exp_en;
    logic        exp_taken;
    logic [31:0] pc;
    logic [31:0] upd_pc;
    logic [31:0] upd_target;
    logic [31:0] pred_next_pc;
    logic [31:0] exp_next_pc;
    logic [4:0]  upd_idx;
    logic [4:0]  pht_index;
    logic [4:0]  exp_index;
    opcode_t     upd_op;
    logic [31:0] lfsr_q;
    row_t        rows[$];
    int          checks;
    int          mismatches;
    int          failures;
    int          timeouts;

    bpred_top uut (
        .clk             (clk),
        .reset_i         (reset),
        .pc_i            (pc),
        .pred_next_pc_o  (pred_next_pc),
        .pred_taken_o    (pred_taken),
        .pht_index_o     (pht_index),
        .ghr_clear_i     (ghr_clear),
        .upd_req_i       (upd_req),
        .upd_pc_i        (upd_pc),
        .upd_op_i        (upd_op),
        .upd_taken_i     (upd_taken),
        .upd_target_i    (upd_target),
        .upd_pht_index_i (upd_idx),
        .upd_ack_o       (upd_ack)
    );

    bpred_checker #(
        .num_btb_entries (btb_entries),
        .num_ghr_bits    (ghr_bits)
    ) u_checker (
        .clk             (clk),
        .reset_i         (reset),
        .pc_i            (pc),
        .ghr_clear_i     (ghr_clear),
        .upd_req_i       (upd_req),
        .upd_pc_i        (upd_pc),
        .upd_op_i        (upd_op),
        .upd_taken_i     (upd_taken),
        .upd_target_i    (upd_target),
        .upd_pht_index_i (upd_idx),
        .upd_ack_i       (upd_ack),
        .pred_next_pc_i  (pred_next_pc),
        .pred_taken_i    (pred_taken),
        .pht_index_i     (pht_index),
        .lookup_en_i     (lookup_en),
        .exp_en_i        (exp_en),
        .exp_next_pc_i   (exp_next_pc),
        .exp_taken_i     (exp_taken),
        .exp_index_i     (exp_index),
        .checks_o        (checks),
        .mismatches_o    (mismatches),
        .failures_o      (failures)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = {val[30:0], lfsr_q[0]};
        end
    endtask

    task automatic add_row(input kind_t kind, input logic [31:0] pc_v, input opcode_t op_v,
                           input logic taken_v, input logic [31:0] addr_v,
                           input logic [4:0] idx_v);
        row_t r;
        r.kind  = kind;
        r.pc    = pc_v;
        r.op    = op_v;
        r.taken = taken_v;
        r.addr  = addr_v;
        r.idx   = idx_v;
        rows.push_back(r);
    endtask

    // Drives one update through the four-phase handshake
    // Entered 5 ns after a rising edge
    task automatic send_update(input logic [31:0] pc_v, input opcode_t op_v,
                               input logic taken_v, input logic [31:0] target_v,
                               input logic [4:0] idx_v, input int hold_v);
        int waited;
        upd_pc     = pc_v;
        upd_op     = op_v;
        upd_taken  = taken_v;
        upd_target = target_v;
        upd_idx    = idx_v;
        upd_req    = 1'b1;
        waited = 0;
        while (!upd_ack && waited < ack_timeout) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (!upd_ack) begin
            timeouts++;
            $display("ERROR time=%0t: no ack within %0d cycles of the request", $time, waited);
        end
        // Requester may keep req high for a few cycles after ack
        for (int h = 0; h < hold_v; h++) begin
            @(posedge clk);
            #5;
        end
        upd_req = 1'b0;
        waited = 0;
        while (upd_ack && waited < ack_timeout) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (upd_ack) begin
            timeouts++;
            $display("ERROR time=%0t: ack did not fall after the request dropped", $time);
        end
    endtask

    task automatic probe_lookup(input logic [31:0] pc_v, input logic check_v,
                                input logic [31:0] next_v, input logic taken_v,
                                input logic [4:0] idx_v);
        pc          = pc_v;
        lookup_en   = 1'b1;
        exp_en      = check_v;
        exp_next_pc = next_v;
        exp_taken   = taken_v;
        exp_index   = idx_v;
        @(posedge clk);
        #5;
        lookup_en = 1'b0;
        exp_en    = 1'b0;
    endtask

    task automatic clear_history();
        ghr_clear = 1'b1;
        @(posedge clk);
        #5;
        ghr_clear = 1'b0;
    endtask

    initial begin
        logic [31:0] sel;
        logic [31:0] word;
        logic [31:0] code;
        logic [31:0] outcome;
        logic [31:0] tgt;
        logic [31:0] idx;
        logic [31:0] hold;
        opcode_t     r_op;
        lfsr_q    = 32'hd94aec60;
        timeouts  = 0;
        reset     = 1'b1;
        pc        = '0;
        ghr_clear = 1'b0;
        upd_req   = 1'b0;
        upd_pc    = '0;
        upd_op    = op_none;
        upd_taken = 1'b0;
        upd_target = '0;
        upd_idx   = '0;
        lookup_en = 1'b0;
        exp_en    = 1'b0;
        exp_next_pc = '0;
        exp_taken = 1'b0;
        exp_index = '0;
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;

        // Cold tables miss
        add_row(k_lookup, 32'h100, op_none, 1'b0, 32'h104, 5'h00);
        add_row(k_lookup, 32'h20c, op_none, 1'b0, 32'h210, 5'h03);
        // Jumps hit on a full tag match only
        add_row(k_update, 32'h100, op_jal, 1'b1, 32'h400, 5'h00);
        add_row(k_lookup, 32'h100, op_none, 1'b1, 32'h400, 5'h00);
        add_row(k_lookup, 32'h110, op_none, 1'b0, 32'h114, 5'h04);
        add_row(k_update, 32'h104, op_jalr, 1'b1, 32'h500, 5'h01);
        add_row(k_lookup, 32'h104, op_none, 1'b1, 32'h500, 5'h01);
        // Counter training at index 2 with the history cleared before each lookup
        add_row(k_update, 32'h208, op_branch, 1'b1, 32'h600, 5'h02);
        add_row(k_clear, 32'h0, op_none, 1'b0, 32'h0, 5'h00);
        add_row(k_lookup, 32'h208, op_none, 1'b0, 32'h20c, 5'h02);
        add_row(k_update, 32'h208, op_branch, 1'b1, 32'h600, 5'h02);
        add_row(k_clear, 32'h0, op_none, 1'b0, 32'h0, 5'h00);
        add_row(k_lookup, 32'h208, op_none, 1'b1, 32'h600, 5'h02);
        add_row(k_update, 32'h208, op_branch, 1'b1, 32'h600, 5'h02);
        add_row(k_update, 32'h208, op_branch, 1'b1, 32'h600, 5'h02);
        add_row(k_update, 32'h208, op_branch, 1'b0, 32'h600, 5'h02);
        add_row(k_update, 32'h208, op_branch, 1'b0, 32'h600, 5'h02);
        add_row(k_clear, 32'h0, op_none, 1'b0, 32'h0, 5'h00);
        add_row(k_lookup, 32'h208, op_none, 1'b0, 32'h20c, 5'h02);
        add_row(k_update, 32'h208, op_branch, 1'b0, 32'h600, 5'h02);
        add_row(k_update, 32'h208, op_branch, 1'b0, 32'h600, 5'h02);
        add_row(k_update, 32'h208, op_branch, 1'b1, 32'h600, 5'h02);
        add_row(k_update, 32'h208, op_branch, 1'b1, 32'h600, 5'h02);
        add_row(k_clear, 32'h0, op_none, 1'b0, 32'h0, 5'h00);
        add_row(k_lookup, 32'h208, op_none, 1'b1, 32'h600, 5'h02);
        // History 1,0,1 gives GHR 5'h14
        add_row(k_update, 32'h30c, op_branch, 1'b1, 32'h700, 5'h03);
        add_row(k_update, 32'h30c, op_branch, 1'b0, 32'h700, 5'h13);
        add_row(k_update, 32'h30c, op_branch, 1'b1, 32'h700, 5'h0b);
        add_row(k_lookup, 32'h30c, op_none, 1'b0, 32'h310, 5'h17);
        add_row(k_lookup, 32'h208, op_none, 1'b0, 32'h20c, 5'h16);
        add_row(k_clear, 32'h0, op_none, 1'b0, 32'h0, 5'h00);
        add_row(k_lookup, 32'h30c, op_none, 1'b0, 32'h310, 5'h03);
        // New target replaces the old one; a plain ALU op leaves everything alone
        add_row(k_update, 32'h100, op_jal, 1'b1, 32'h480, 5'h00);
        add_row(k_lookup, 32'h100, op_none, 1'b1, 32'h480, 5'h00);
        add_row(k_update, 32'h100, op_none, 1'b1, 32'h900, 5'h00);
        add_row(k_lookup, 32'h100, op_none, 1'b1, 32'h480, 5'h00);

        foreach (rows[i]) begin
            case (rows[i].kind)
                k_update: send_update(rows[i].pc, rows[i].op, rows[i].taken, rows[i].addr,
                                      rows[i].idx, 0);
                k_lookup: probe_lookup(rows[i].pc, 1'b1, rows[i].addr, rows[i].taken,
                                       rows[i].idx);
                default:  clear_history();
            endcase
        end

        // 32 word PCs over 4 BTB entries, so tags collide often
        for (int n = 0; n < num_random; n++) begin
            draw_bits(3, sel);
            draw_bits(5, word);
            if (sel < 4) begin
                probe_lookup(32'h1000 + (word << 2), 1'b0, '0, 1'b0, '0);
            end else if (sel == 7) begin
                clear_history();
            end else begin
                draw_bits(3, code);
                case (code)
                    0:       r_op = op_jal;
                    1:       r_op = op_jalr;
                    2:       r_op = op_none;
                    default: r_op = op_branch;
                endcase
                draw_bits(1, outcome);
                draw_bits(8, tgt);
                draw_bits(5, idx);
                draw_bits(2, hold);
                send_update(32'h1000 + (word << 2), r_op, outcome[0], 32'h2000 + (tgt << 2),
                            idx[4:0], hold);
            end
        end

        @(posedge clk);
        #5;
        $display("checks=%0d mismatches=%0d other errors=%0d timeouts=%0d",
                 checks, mismatches, failures, timeouts);
        if (mismatches == 0 && failures == 0 && timeouts == 0 && checks > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- list.f
bpred_pkg.sv
bpred_btb.sv
bpred_gshare.sv
bpred_next_pc.sv
bpred_update_ctrl.sv
bpred_top.sv
bpred_checker.sv
bpred_tb.sv

//--- Bender.yml
package:
  name: bpred

sources:
  - bpred_pkg.sv
  - bpred_btb.sv
  - bpred_gshare.sv
  - bpred_next_pc.sv
  - bpred_update_ctrl.sv
  - bpred_top.sv
  - target: test
    files:
      - bpred_checker.sv
      - bpred_tb.sv
